// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LED display testbench with Verilator

LOG=sim.log
SIM=led_display_sim

verilator --binary --timing --assert --top-module led_display_tb -f tb.f -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
exit 0

// ==== src/axi_lite_regs.sv ====
module axi_lite_regs
    import led_display_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // AXI4-Lite slave
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    // Status in
    input  logic        fault,
    // Register outputs
    output logic [1:0]  channel,
    output logic        debug_color,
    output logic        en_7s_frame,
    output logic [23:0] rgb0,
    output logic [23:0] rgb1,
    output logic [23:0] rgb2,
    output logic [23:0] rgb3,
    output logic        frame_wr,
    output logic [8:0]  frame_data,
    output logic        fault_clr
);

    logic        wr_ready;
    logic        wr_take;
    logic        rd_take;
    logic [31:0] rd_word;

    assign awready = wr_ready; // Address and data accepted together
    assign wready  = wr_ready;
    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;

    assign wr_take = wr_ready && awvalid && wvalid;
    assign rd_take = arready && arvalid;

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            // One-cycle ready pulse, only with no response pending
            wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;
            if (wr_take)
                bvalid <= 1'b1;
            else if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            channel     <= 2'b00;
            debug_color <= 1'b0;
            en_7s_frame <= 1'b0;
            rgb0        <= '0;
            rgb1        <= '0;
            rgb2        <= '0;
            rgb3        <= '0;
            frame_wr    <= 1'b0;
            fault_clr   <= 1'b0;
        end else begin
            frame_wr  <= wr_take && (awaddr == ADDR_FRAME);
            fault_clr <= wr_take && (awaddr == ADDR_STATUS); // Any value clears
            if (wr_take) begin
                case (awaddr)
                    ADDR_CTRL: begin
                        channel     <= wdata[CTRL_CHANNEL_LSB +: 2];
                        debug_color <= wdata[CTRL_DEBUG_BIT];
                        en_7s_frame <= wdata[CTRL_FRAME_BIT];
                    end
                    ADDR_RGB0: rgb0 <= wdata[23:0];
                    ADDR_RGB1: rgb1 <= wdata[23:0];
                    ADDR_RGB2: rgb2 <= wdata[23:0];
                    ADDR_RGB3: rgb3 <= wdata[23:0];
                    default: ; // Unknown address ignored
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take && (awaddr == ADDR_FRAME))
            frame_data <= wdata[8:0];
    end

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        case (araddr)
            ADDR_CTRL: begin
                rd_word[CTRL_CHANNEL_LSB +: 2] = channel;
                rd_word[CTRL_DEBUG_BIT]        = debug_color;
                rd_word[CTRL_FRAME_BIT]        = en_7s_frame;
            end
            ADDR_RGB0:   rd_word[23:0] = rgb0;
            ADDR_RGB1:   rd_word[23:0] = rgb1;
            ADDR_RGB2:   rd_word[23:0] = rgb2;
            ADDR_RGB3:   rd_word[23:0] = rgb3;
            ADDR_FRAME:  rd_word[8:0]  = frame_data;
            ADDR_STATUS: rd_word[0]    = fault;
            default:     rd_word       = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_take)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take)
            rdata <= rd_word;
    end

endmodule

// ==== src/frame_checker.sv ====
module frame_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic       frame_wr,
    input  logic [8:0] frame_data,
    input  logic       fault_clr,
    output logic       frame_valid,
    output logic [7:0] frame,
    output logic       fault
);

    logic parity_ok;
    logic good_frame;
    logic bad_frame;

    // Odd parity over data and parity bit together
    assign parity_ok  = ^frame_data;
    assign good_frame = frame_wr && parity_ok;
    assign bad_frame  = frame_wr && !parity_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_valid <= 1'b0;
            fault       <= 1'b0;
        end else begin
            frame_valid <= good_frame;
            // Sticky; a new parity error wins over a clear
            if (bad_frame)
                fault <= 1'b1;
            else if (fault_clr)
                fault <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (good_frame)
            frame <= frame_data[7:0];
    end

endmodule

// ==== src/led_display_pkg.sv ====
package led_display_pkg;

    localparam int DIGIT_COUNT = 8;

    // Register map, byte addresses
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_RGB0   = 8'h04;
    localparam logic [7:0] ADDR_RGB1   = 8'h08;
    localparam logic [7:0] ADDR_RGB2   = 8'h0C;
    localparam logic [7:0] ADDR_RGB3   = 8'h10;
    localparam logic [7:0] ADDR_FRAME  = 8'h14;
    localparam logic [7:0] ADDR_STATUS = 8'h18;

    // CTRL fields
    localparam int CTRL_CHANNEL_LSB = 0; // Two bits wide
    localparam int CTRL_DEBUG_BIT   = 4;
    localparam int CTRL_FRAME_BIT   = 5;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Display word, read as nibbles by the scanner or as channel plus colour
    typedef union packed {
        logic [DIGIT_COUNT-1:0][3:0] nibble;
        struct packed {
            logic [23:0] colour;
            logic [5:0]  pad;
            logic [1:0]  channel;
        } colour_view;
    } display_word_t;

    // Segments gfedcba, active high
    function automatic logic [6:0] hex_font(input logic [3:0] value);
        logic [6:0] seg;
        case (value)
            4'h0: seg = 7'b0111111;
            4'h1: seg = 7'b0000110;
            4'h2: seg = 7'b1011011;
            4'h3: seg = 7'b1001111;
            4'h4: seg = 7'b1100110;
            4'h5: seg = 7'b1101101;
            4'h6: seg = 7'b1111101;
            4'h7: seg = 7'b0000111;
            4'h8: seg = 7'b1111111;
            4'h9: seg = 7'b1101111;
            4'hA: seg = 7'b1110111;
            4'hB: seg = 7'b1111100; // Lower case b
            4'hC: seg = 7'b0111001;
            4'hD: seg = 7'b1011110; // Lower case d
            4'hE: seg = 7'b1111001;
            default: seg = 7'b1110001;
        endcase
        return seg;
    endfunction

endpackage

// ==== src/led_display_top.sv ====
module led_display_top
    import led_display_pkg::*;
#(
    parameter int DIGIT_CYCLES    = 50000,
    parameter bit FONT_ACTIVE_LOW = 1'b1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic [6:0]  seg,
    output logic [7:0]  an
);

    logic [1:0]    channel;
    logic          debug_color;
    logic          en_7s_frame;
    logic [23:0]   rgb0, rgb1, rgb2, rgb3;
    logic          frame_wr;
    logic [8:0]    frame_data;
    logic          fault_clr;
    logic          frame_valid;
    logic [7:0]    frame;
    logic          fault;
    display_word_t digit;
    logic [7:0]    en_digit;

    axi_lite_regs u_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .fault(fault),
        .channel(channel), .debug_color(debug_color), .en_7s_frame(en_7s_frame),
        .rgb0(rgb0), .rgb1(rgb1), .rgb2(rgb2), .rgb3(rgb3),
        .frame_wr(frame_wr), .frame_data(frame_data), .fault_clr(fault_clr)
    );

    frame_checker u_checker (
        .clk(clk), .rst(rst),
        .frame_wr(frame_wr), .frame_data(frame_data), .fault_clr(fault_clr),
        .frame_valid(frame_valid), .frame(frame), .fault(fault)
    );

    seven_segment_interface u_interface (
        .clk(clk), .rst(rst),
        .en_7s_frame(en_7s_frame), .debug_color(debug_color), .fault(fault),
        .frame_valid(frame_valid), .frame(frame), .channel(channel),
        .rgb0(rgb0), .rgb1(rgb1), .rgb2(rgb2), .rgb3(rgb3),
        .digit(digit), .en_digit(en_digit)
    );

    seven_segment_scan #(
        .DIGIT_CYCLES(DIGIT_CYCLES),
        .FONT_ACTIVE_LOW(FONT_ACTIVE_LOW)
    ) u_scan (
        .clk(clk), .rst(rst),
        .digit(digit), .en_digit(en_digit),
        .seg(seg), .an(an)
    );

endmodule

// ==== src/seven_segment_interface.sv ====
module seven_segment_interface
    import led_display_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          en_7s_frame,
    input  logic          debug_color,
    input  logic          fault,
    input  logic          frame_valid,
    input  logic [7:0]    frame,
    input  logic [1:0]    channel,
    input  logic [23:0]   rgb0,
    input  logic [23:0]   rgb1,
    input  logic [23:0]   rgb2,
    input  logic [23:0]   rgb3,
    output display_word_t digit,
    output logic [7:0]    en_digit
);

    display_word_t digit_nxt;
    logic [7:0]    en_digit_nxt;
    logic [7:0]    frame_q;
    logic [7:0]    frame_cur;
    logic          frame_seen;
    logic          frame_seen_nxt;
    logic [23:0]   colour_sel;

    // A frame arriving this cycle is shown right away
    assign frame_cur      = frame_valid ? frame : frame_q;
    assign frame_seen_nxt = frame_seen || frame_valid;

    always_comb begin
        case (channel)
            2'd0:    colour_sel = rgb0;
            2'd1:    colour_sel = rgb1;
            2'd2:    colour_sel = rgb2;
            default: colour_sel = rgb3;
        endcase
    end

    always_comb begin
        digit_nxt    = digit;
        en_digit_nxt = en_digit;
        if (!en_7s_frame) begin
            if (debug_color) begin
                digit_nxt.colour_view.colour  = colour_sel;
                digit_nxt.colour_view.pad     = '0;
                digit_nxt.colour_view.channel = channel;
                en_digit_nxt = 8'b1111_1101; // Digit 1 kept dark
            end else if (fault) begin
                digit_nxt.nibble    = '0;
                digit_nxt.nibble[0] = {2'b00, channel};
                digit_nxt.nibble[7] = 4'hF;
                en_digit_nxt = 8'b1000_0001;
            end else begin
                digit_nxt.nibble    = '0;
                digit_nxt.nibble[0] = {2'b00, channel};
                en_digit_nxt = 8'b0000_0001;
            end
        end else if (frame_seen_nxt) begin
            // One frame bit per digit
            for (int k = 0; k < DIGIT_COUNT; k++) begin
                digit_nxt.nibble[k] = {3'b000, frame_cur[k]};
            end
            en_digit_nxt = 8'b1111_1111;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digit      <= '1;
            en_digit   <= '0;
            frame_seen <= 1'b0;
        end else begin
            digit      <= digit_nxt;
            en_digit   <= en_digit_nxt;
            frame_seen <= frame_seen_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid)
            frame_q <= frame;
    end

endmodule

// ==== src/seven_segment_scan.sv ====
module seven_segment_scan
    import led_display_pkg::*;
#(
    parameter int DIGIT_CYCLES    = 50000,
    parameter bit FONT_ACTIVE_LOW = 1'b1
) (
    input  logic          clk,
    input  logic          rst,
    input  display_word_t digit,
    input  logic [7:0]    en_digit,
    output logic [6:0]    seg,
    output logic [7:0]    an
);

    localparam int CNT_W = (DIGIT_CYCLES > 1) ? $clog2(DIGIT_CYCLES) : 1;
    localparam int IDX_W = $clog2(DIGIT_COUNT);

    logic [CNT_W-1:0] cycle_cnt;
    logic [IDX_W-1:0] digit_idx;
    logic [6:0]       font_seg;
    logic             slot_end;

    assign font_seg = hex_font(digit.nibble[digit_idx]);
    assign slot_end = (cycle_cnt == CNT_W'(DIGIT_CYCLES - 1));

    ////////////////////////////////////////////////////////////
    // Slot timing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
            digit_idx <= '0;
        end else if (slot_end) begin
            cycle_cnt <= '0;
            if (digit_idx == IDX_W'(DIGIT_COUNT - 1))
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Segment and anode outputs
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg <= FONT_ACTIVE_LOW ? 7'h7F : 7'h00; // All segments off
            an  <= '1;
        end else begin
            seg <= FONT_ACTIVE_LOW ? ~font_seg : font_seg;
            if (en_digit[digit_idx])
                an <= ~(8'd1 << digit_idx); // One-cold anode
            else
                an <= '1;
        end
    end

endmodule

// ==== tb.f ====
src/led_display_pkg.sv
src/axi_lite_regs.sv
src/frame_checker.sv
src/seven_segment_interface.sv
src/seven_segment_scan.sv
src/led_display_top.sv
testbench/led_display_properties.sv
testbench/led_display_tb.sv

// ==== testbench/led_display_properties.sv ====
module led_display_properties (
    input logic       clk,
    input logic       rst,
    input logic       awvalid,
    input logic       awready,
    input logic       wvalid,
    input logic       wready,
    input logic       bvalid,
    input logic       bready,
    input logic       rvalid,
    input logic       rready,
    input logic [7:0] an
);

    int unsigned fail_count = 0;

    // Responses hold until the master takes them
    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    anode_one_cold: assert property (@(posedge clk) disable iff (rst)
        $countones(~an) <= 1)
        else begin
            fail_count++;
            $error("More than one anode driven low");
        end

    // Both readies together, only for a full request with no response pending
    ready_paired: assert property (@(posedge clk) disable iff (rst)
        (awready || wready) |-> (awready && wready && awvalid && wvalid && !bvalid))
        else begin
            fail_count++;
            $error("Write ready without a paired request or with a response pending");
        end

endmodule

bind led_display_top led_display_properties u_props (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready),
    .wvalid(wvalid), .wready(wready),
    .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready),
    .an(an)
);

// ==== testbench/led_display_tb.sv ====
module led_display_tb
    import led_display_pkg::*;
();

    localparam int DIGIT_CYCLES = 4;
    localparam int SCAN_CYCLES  = DIGIT_CYCLES * DIGIT_COUNT;
    localparam int TIMEOUT      = 4 * SCAN_CYCLES;
    localparam int SETTLE       = 10;
    localparam int FRAME_NONE   = 0;
    localparam int FRAME_GOOD   = 1;
    localparam int FRAME_BAD    = 2;

    // Active-high segments gfedcba for hex digits 0 to F
    localparam logic [6:0] FONT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    typedef struct {
        string       name;
        bit          do_ctrl;
        logic [31:0] ctrl;
        bit          do_rgb;     // Write all four colours
        int          frame_kind;
        bit          clr;        // Write to STATUS
        bit          exp_fault;
    } step_t;

    logic          clk = 1'b0;
    logic          rst;
    logic [7:0]    awaddr;
    logic          awvalid;
    logic          awready;
    logic [31:0]   wdata;
    logic          wvalid;
    logic          wready;
    logic [1:0]    bresp;
    logic          bvalid;
    logic          bready;
    logic [7:0]    araddr;
    logic          arvalid;
    logic          arready;
    logic [31:0]   rdata;
    logic [1:0]    rresp;
    logic          rvalid;
    logic          rready;
    logic [6:0]    seg;
    logic [7:0]    an;

    step_t         steps[$];
    logic [23:0]   colour [4];
    logic [31:0]   ctrl_q;      // Last CTRL value written
    logic          frame_seen;
    logic [7:0]    last_frame;
    display_word_t exp_word;
    logic [7:0]    exp_en;

    always #2 clk = ~clk;

    led_display_top #(
        .DIGIT_CYCLES(DIGIT_CYCLES),
        .FONT_ACTIVE_LOW(1'b1)
    ) uut (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .seg(seg), .an(an)
    );

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (actual !== expected)
            stop_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    // DUT outputs are stable at the falling edge
    task automatic wait_cycle(inout int waited, input string what);
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT)
            stop_run($sformatf("Timeout while waiting for %s", what));
    endtask

    task automatic add_step(input string name, input bit do_ctrl, input logic [31:0] ctrl,
                            input bit do_rgb, input int frame_kind, input bit clr,
                            input bit exp_fault);
        step_t st;
        st.name       = name;
        st.do_ctrl    = do_ctrl;
        st.ctrl       = ctrl;
        st.do_rgb     = do_rgb;
        st.frame_kind = frame_kind;
        st.clr        = clr;
        st.exp_fault  = exp_fault;
        steps.push_back(st);
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////////////////////////

    task automatic start_write(input logic [7:0] addr, input logic [31:0] data);
        int waited = 0;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do
            wait_cycle(waited, "awready");
        while (!awready);
        compare_values("wready_with_awready", 32'h1, 32'(wready));
        @(posedge clk); // Handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic finish_write(input string name);
        int waited = 0;
        do
            wait_cycle(waited, "bvalid");
        while (!bvalid);
        compare_values({name, "_bresp"}, 32'(RESP_OKAY), 32'(bresp));
        @(posedge clk);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        start_write(addr, data);
        finish_write("write");
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int waited = 0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do
            wait_cycle(waited, "arready");
        while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        waited = 0;
        do
            wait_cycle(waited, "rvalid");
        while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Display model and checks
    ////////////////////////////////////////////////////////////

    task automatic predict_display(input bit fault);
        logic [1:0] ch;
        ch = ctrl_q[CTRL_CHANNEL_LSB +: 2];
        if (!ctrl_q[CTRL_FRAME_BIT]) begin
            if (ctrl_q[CTRL_DEBUG_BIT]) begin
                exp_word = {colour[ch], 6'b000000, ch};
                exp_en   = 8'b1111_1101;
            end else if (fault) begin
                exp_word = {4'hF, 24'h000000, 2'b00, ch};
                exp_en   = 8'b1000_0001;
            end else begin
                exp_word = {30'h0, ch};
                exp_en   = 8'b0000_0001;
            end
        end else if (frame_seen) begin
            for (int k = 0; k < DIGIT_COUNT; k++)
                exp_word.nibble[k] = {3'b000, last_frame[k]};
            exp_en = 8'hFF;
        end
    endtask

    task automatic check_display(input string name);
        int         waited;
        logic [6:0] want;
        repeat (SETTLE) @(posedge clk);
        for (int k = 0; k < DIGIT_COUNT; k++) begin
            if (exp_en[k]) begin
                waited = 0;
                do
                    wait_cycle(waited, $sformatf("anode of digit %0d", k));
                while (an !== ~(8'd1 << k));
                want = ~FONT[exp_word.nibble[k]];
                compare_values($sformatf("%s_digit%0d", name, k), 32'(want), 32'(seg));
            end else begin
                // Dark digit must stay off for one full scan
                for (int c = 0; c < SCAN_CYCLES; c++) begin
                    @(negedge clk);
                    if (an[k] !== 1'b1)
                        stop_run($sformatf("%s: disabled digit %0d was lit", name, k));
                end
            end
        end
    endtask

    task automatic check_write_backpressure();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] rd_data;
        logic [1:0]  rd_resp;
        int          waited = 0;
        first  = $urandom;
        second = $urandom;
        @(posedge clk);
        bready <= 1'b0;
        start_write(ADDR_RGB3, first);
        do
            wait_cycle(waited, "bvalid");
        while (!bvalid);
        // Second write offered while the first response is pending
        @(posedge clk);
        wdata   <= second;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        repeat (8) begin
            @(negedge clk);
            compare_values("bvalid_held", 32'h1, 32'(bvalid));
            compare_values("write_blocked", 32'h0, 32'(awready));
            compare_values("write_blocked_wready", 32'h0, 32'(wready));
        end
        @(posedge clk);
        bready <= 1'b1;
        waited = 0;
        do
            wait_cycle(waited, "awready after bready");
        while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        finish_write("second_write");
        read_reg(ADDR_RGB3, rd_data, rd_resp);
        compare_values("rgb3_readback", {8'h00, second[23:0]}, rd_data);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd_data;
        logic [1:0]  rd_resp;
        logic [7:0]  fbyte;
        step_t       st;

        void'($urandom(32'h3896e47c));
        rst        = 1'b1;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b1;
        ctrl_q     = '0;
        frame_seen = 1'b0;
        last_frame = '0;
        for (int i = 0; i < 4; i++)
            colour[i] = 24'($urandom);

        add_step("reset_default", 1'b0, 32'h00, 1'b0, FRAME_NONE, 1'b0, 1'b0);
        add_step("channel_0",     1'b1, 32'h00, 1'b1, FRAME_NONE, 1'b0, 1'b0);
        add_step("channel_1",     1'b1, 32'h01, 1'b0, FRAME_NONE, 1'b0, 1'b0);
        add_step("channel_2",     1'b1, 32'h02, 1'b0, FRAME_NONE, 1'b0, 1'b0);
        add_step("channel_3",     1'b1, 32'h03, 1'b0, FRAME_NONE, 1'b0, 1'b0);
        add_step("debug_ch2",     1'b1, 32'h12, 1'b0, FRAME_NONE, 1'b0, 1'b0);
        add_step("debug_ch1",     1'b1, 32'h11, 1'b0, FRAME_NONE, 1'b0, 1'b0);
        add_step("frame_good",    1'b1, 32'h20, 1'b0, FRAME_GOOD, 1'b0, 1'b0);
        add_step("frame_bad",     1'b0, 32'h00, 1'b0, FRAME_BAD,  1'b0, 1'b1);
        add_step("fault_shown",   1'b1, 32'h02, 1'b0, FRAME_NONE, 1'b0, 1'b1);
        add_step("fault_cleared", 1'b0, 32'h00, 1'b0, FRAME_NONE, 1'b1, 1'b0);

        // Anodes stay off while reset is held
        repeat (10) begin
            @(negedge clk);
            compare_values("reset_dark", 32'hFF, 32'(an));
        end
        @(posedge clk);
        rst <= 1'b0;

        foreach (steps[s]) begin
            st = steps[s];
            if (st.do_ctrl) begin
                write_reg(ADDR_CTRL, st.ctrl);
                ctrl_q = st.ctrl;
            end
            if (st.do_rgb)
                for (int i = 0; i < 4; i++)
                    write_reg(ADDR_RGB0 + 8'(4 * i), {8'h00, colour[i]});
            if (st.frame_kind != FRAME_NONE) begin
                fbyte = 8'($urandom);
                if (st.frame_kind == FRAME_GOOD) begin
                    write_reg(ADDR_FRAME, {23'h0, ~^fbyte, fbyte}); // Odd parity
                    frame_seen = 1'b1;
                    last_frame = fbyte;
                end else begin
                    write_reg(ADDR_FRAME, {23'h0, ^fbyte, fbyte});
                end
            end
            if (st.clr)
                write_reg(ADDR_STATUS, $urandom);
            predict_display(st.exp_fault);
            check_display(st.name);
            read_reg(ADDR_STATUS, rd_data, rd_resp);
            compare_values({st.name, "_fault"}, 32'(st.exp_fault), 32'(rd_data[0]));
            compare_values({st.name, "_rresp"}, 32'(RESP_OKAY), 32'(rd_resp));
        end

        read_reg(8'h3C, rd_data, rd_resp); // Outside the register map
        compare_values("unknown_addr_data", 32'h0, rd_data);
        compare_values("unknown_addr_rresp", 32'(RESP_OKAY), 32'(rd_resp));

        check_write_backpressure();

        if (uut.u_props.fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_run($sformatf("%0d assertion failures", uut.u_props.fail_count));
        end
    end

endmodule
